/* edma_patterns.txt */
// mode stride count srcaddr dstaddr ptr chain, one test per line, all hex
// mode 3:0 manual chain master en; stride and count are outer:inner; chain links next line
0000000a 00040004 00010001 00001000 00002000 00000000 00000000
0000000b 00400004 00020003 00001000 00008000 00000000 00000000
0000000b fff0fffc 00010002 00003000 00009100 00000000 00000000
00000009 00100008 00010003 00002000 0000a000 00000000 00000000
00000003 00200004 00010001 00004000 0000a800 00000040 00000000
00000001 00080002 00000004 00004800 0000b000 00000080 00000000
00000007 00100004 00010001 00005000 0000b800 000000c0 00000001
00000003 00100008 00000002 00006000 0000c000 00000100 00000000
00000005 fff80004 00020001 00007000 0000c800 00000140 00000001
00000001 00040004 00010002 00007800 0000d000 00000180 00000000

/* files.f */
+incdir+.
edma_pkg.sv
edma_ctrl_if.sv
edma_regs.sv
edma_ctrl.sv
edma.sv
tb_edma.sv

/* Bender.yml */
package:
  name: edma

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - edma_pkg.sv
      - edma_ctrl_if.sv
      - edma_regs.sv
      - edma_ctrl.sv
      - edma.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_edma.sv

/* tb_edma.sv */
// edma channel testbench
`default_nettype none

`include "edma_settings.svh"

module tb_edma
  import edma_pkg::*;
();

  localparam int NF   = 7;                   // words per pattern line
  localparam int MAXL = 16;                  // pattern lines at most

  logic                clk;
  logic                nreset;
  logic                reg_access;
  logic [`EDMA_PW-1:0] reg_packet;
  logic                fetch_wait;
  logic                fetch_access;
  logic [`EDMA_PW-1:0] fetch_packet;
  logic                access_in;
  logic                wait_in;
  logic                access_out;
  logic                update;
  logic [`EDMA_AW-1:0] srcaddr;
  logic [`EDMA_AW-1:0] dstaddr;
  edma_state_t         dma_state;

  logic [31:0]         pat [0:NF*MAXL-1];
  logic [31:0]         mem [0:255];          // descriptor memory by word index
  logic [31:0]         lfsr;
  logic [`EDMA_PW-1:0] fetch_q [$];          // accepted fetches awaiting reply
  logic [`EDMA_PW-1:0] held_pkt;
  logic                held;                 // fetch stalled last cycle
  logic                rnd_on;
  logic                slave;                // beats paced by access_in
  logic [31:0]         d_str [0:1];          // descriptors of the running test
  logic [31:0]         d_cnt [0:1];
  logic [31:0]         d_src [0:1];
  logic [31:0]         d_dst [0:1];
  logic [15:0]         d_ptr [0:1];
  int                  nd;
  int                  beats;
  int                  fetches;
  int                  total0;
  int                  total;
  int                  errors;
  int                  n_fail;
  int                  cycles;
  int                  limit;

  edma dut (
    .clk          (clk),
    .nreset       (nreset),
    .reg_access   (reg_access),
    .reg_packet   (reg_packet),
    .fetch_wait   (fetch_wait),
    .fetch_access (fetch_access),
    .fetch_packet (fetch_packet),
    .access_in    (access_in),
    .wait_in      (wait_in),
    .access_out   (access_out),
    .update       (update),
    .srcaddr      (srcaddr),
    .dstaddr      (dstaddr),
    .dma_state    (dma_state)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ####################
  // helpers
  // ####################
  // galois lfsr stepped once per bit
  function automatic logic lfsr_bit();
    logic b;
    b    = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [4:0] idx);
    return {21'h0, `EDMA_ID, idx, 2'b00};
  endfunction

  function automatic int desc_beats(input logic [31:0] cnt);
    return (cnt[31:16] + 1) * (cnt[15:0] + 1);   // rows times row length
  endfunction

  // k-th beat address from the 2d walk
  function automatic logic [31:0] beat_addr(input logic [31:0] base, input logic [31:0] str,
                                            input logic [31:0] cnt, input int k);
    int n;
    int sin;
    int sout;
    n    = cnt[15:0] + 1;                    // beats per row
    sin  = $signed(str[15:0]);
    sout = $signed(str[31:16]);
    return base + (k / n) * ((n - 1) * sin + sout) + (k % n) * sin;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    logic [`EDMA_PW-1:0] pkt;
    pkt                          = '0;
    pkt[`EDMA_P_WRITE]           = 1'b1;
    pkt[`EDMA_P_DST +: `EDMA_AW]  = addr;
    pkt[`EDMA_P_DATA +: `EDMA_AW] = data;
    @(posedge clk);
    reg_access <= 1'b1;
    reg_packet <= pkt;
  endtask

  task automatic release_bus();
    @(posedge clk);
    reg_access <= 1'b0;
  endtask

  // copy one pattern line into the model memory
  task automatic load_desc(input int d, input int l, input logic [15:0] next);
    logic [7:0] w;
    d_str[d]   = pat[l*NF+1];
    d_cnt[d]   = pat[l*NF+2];
    d_src[d]   = pat[l*NF+3];
    d_dst[d]   = pat[l*NF+4];
    d_ptr[d]   = pat[l*NF+5][15:0];
    w          = d_ptr[d][9:2];
    mem[w]     = {next, 12'h0, pat[l*NF][3:0]};
    mem[w + 1] = d_str[d];
    mem[w + 2] = d_cnt[d];
    mem[w + 3] = {16'h5a5a, d_ptr[d]};      // spare word
    mem[w + 4] = d_src[d];
    mem[w + 5] = d_dst[d];
  endtask

  // ####################
  // stimulus and memory
  // ####################
  always @(posedge clk) begin
    if (rnd_on) begin
      wait_in    <= lfsr_bit() & lfsr_bit();   // stall about a quarter
      fetch_wait <= lfsr_bit() & lfsr_bit();
      access_in  <= slave & lfsr_bit();
    end
  end

  // each fetch gets two register writes back
  always begin : mem_model
    logic [`EDMA_PW-1:0] req;
    logic [31:0]         a;
    logic [31:0]         ra;
    @(posedge clk);
    if (fetch_q.size() > 0) begin
      req = fetch_q.pop_front();
      a   = req[`EDMA_P_DST +: `EDMA_AW] >> 2;
      ra  = req[`EDMA_P_SRC +: `EDMA_AW];
      repeat ({lfsr_bit(), lfsr_bit()}) @(posedge clk);
      reg_write(ra, mem[a[7:0]]);
      reg_write(ra + 4, mem[a[7:0] + 8'd1]);
      release_bus();
    end
  end

  // ####################
  // monitor
  // ####################
  always @(negedge clk) begin : monitor
    int d;
    int k;
    if (rnd_on) begin
      if (held) begin
        check(fetch_access, 1, "fetch_access dropped under fetch_wait");
        check(fetch_packet === held_pkt, 1, "fetch packet moved under fetch_wait");
      end
      if (fetch_access && !fetch_wait) begin
        d = fetches / 3;
        k = fetches % 3;
        check(fetch_packet[`EDMA_P_WRITE], 0, "fetch write bit");
        check(fetch_packet[`EDMA_P_DMODE +: 2], 3, "fetch datamode");
        check(fetch_packet[`EDMA_P_DST +: `EDMA_AW], d_ptr[d] + 8 * k, "fetch address");
        check(fetch_packet[`EDMA_P_SRC +: `EDMA_AW],
              reg_addr(k == 0 ? `EDMA_CONFIG : (k == 1 ? `EDMA_COUNT : `EDMA_SRCADDR)),
              "fetch return address");
        fetch_q.push_back(fetch_packet);
        fetches++;
      end
      if (dma_state == INNER || dma_state == OUTER) begin
        check(update, !wait_in && (!slave || access_in), "beat pacing");
        check(access_out, !slave, "access_out");
      end
      if (update && dma_state == INNER) begin
        d = (beats < total0) ? 0 : 1;           // second chained descriptor
        k = beats - d * total0;
        check(srcaddr, beat_addr(d_src[d], d_str[d], d_cnt[d], k), "beat srcaddr");
        check(dstaddr, beat_addr(d_dst[d], d_str[d], d_cnt[d], k), "beat dstaddr");
        beats++;
      end
    end
    held     = fetch_access && fetch_wait;
    held_pkt = fetch_packet;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles waiting on the channel", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ####################
  // test sequence
  // ####################
  initial begin
    int          i;
    int          t;
    int          e0;
    logic [31:0] m;
    lfsr       = 32'h3e04_b26c;
    nreset     = 1'b0;
    reg_access = 1'b0;
    reg_packet = '0;
    fetch_wait = 1'b0;
    access_in  = 1'b0;
    wait_in    = 1'b0;
    rnd_on     = 1'b0;
    slave      = 1'b0;
    held       = 1'b0;
    errors     = 0;
    n_fail     = 0;
    cycles     = 0;
    beats      = 0;
    fetches    = 0;
    foreach (pat[j]) pat[j] = '1;
    foreach (mem[j]) mem[j] = 32'hdead_0000 + j;
    $readmemh("edma_patterns.txt", pat);
    limit = 8;
    for (i = 0; i < MAXL && pat[i*NF] !== '1; i++) begin
      limit += (desc_beats(pat[i*NF+2]) + 40) * 8;
    end
    repeat (8) @(posedge clk);
    nreset <= 1'b1;
    @(negedge clk);
    check(dma_state, IDLE, "state after reset");
    check(fetch_access, 0, "fetch_access after reset");
    check(access_out, 0, "access_out after reset");
    check(update, 0, "update after reset");
    rnd_on = 1'b1;
    i = 0;
    t = 0;
    while (i < MAXL && pat[i*NF] !== '1) begin
      e0 = errors;
      m  = pat[i*NF];
      nd = pat[i*NF+6][0] ? 2 : 1;
      if (nd == 2) begin
        load_desc(1, i + 1, 16'h0);
      end
      load_desc(0, i, (nd == 2) ? d_ptr[1] : 16'h0);
      slave   = !m[`EDMA_CFG_MASTER];
      total0  = desc_beats(d_cnt[0]);
      total   = total0 + ((nd == 2) ? desc_beats(d_cnt[1]) : 0);
      beats   = 0;
      fetches = 0;
      if (!m[`EDMA_CFG_EN]) begin
        // channel sits in IDLE with enable clear
        reg_write(reg_addr(`EDMA_CONFIG), m);
        release_bus();
        repeat (10) @(negedge clk);
        check(dma_state, IDLE, "state with enable clear");
        check(fetch_access, 0, "fetch_access with enable clear");
        total = 0;
      end else begin
        if (m[`EDMA_CFG_MANUAL]) begin
          reg_write(reg_addr(`EDMA_STRIDE), d_str[0]);
          reg_write(reg_addr(`EDMA_COUNT), d_cnt[0]);
          reg_write(reg_addr(`EDMA_SRCADDR), d_src[0]);
          reg_write(reg_addr(`EDMA_DSTADDR), d_dst[0]);
          reg_write(reg_addr(`EDMA_CONFIG), m);
        end else begin
          reg_write(reg_addr(`EDMA_CONFIG), {d_ptr[0], 16'h0001});   // fetch from ptr
        end
        release_bus();
        while (!(dma_state == DONE && beats >= total)) @(posedge clk);
        check(fetches, m[`EDMA_CFG_MANUAL] ? 0 : 3 * nd, "fetch count");
        reg_write(reg_addr(`EDMA_CONFIG), 32'h0);
        release_bus();
        while (dma_state != IDLE) @(posedge clk);
      end
      slave = 1'b0;
      check(beats, total, "beat count");
      if (errors != e0) begin
        n_fail++;
      end
      $display("test %0d mode %h beats %0d %s", t, m[3:0], beats,
               (errors == e0) ? "ok" : "mismatch");
      t++;
      i += nd;
    end
    $display("tests %0d failed %0d errors %0d", t, n_fail, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* edma.sv */
// edma channel top
`default_nettype none

`include "edma_settings.svh"

module edma
  import edma_pkg::*;
(
  input  logic                clk,
  input  logic                nreset,
  // register write port
  input  logic                reg_access,
  input  logic [`EDMA_PW-1:0] reg_packet,
  // descriptor fetch port
  input  logic                fetch_wait,
  output logic                fetch_access,
  output logic [`EDMA_PW-1:0] fetch_packet,
  // beat port
  input  logic                access_in,
  input  logic                wait_in,
  output logic                access_out,
  output logic                update,         // beat strobe
  output logic [`EDMA_AW-1:0] srcaddr,
  output logic [`EDMA_AW-1:0] dstaddr,
  // status
  output edma_state_t         dma_state
);

  // ####################
  // sequencer link
  // ####################
  edma_ctrl_if bus ();

  assign update = bus.update;

  // ####################
  // registers
  // ####################
  edma_regs u_regs (
    .clk        (clk),
    .nreset     (nreset),
    .reg_access (reg_access),
    .reg_packet (reg_packet),
    .srcaddr    (srcaddr),
    .dstaddr    (dstaddr),
    .bus        (bus.regs)
  );

  // ####################
  // sequencer
  // ####################
  edma_ctrl u_ctrl (
    .clk          (clk),
    .nreset       (nreset),
    .fetch_wait   (fetch_wait),
    .access_in    (access_in),
    .wait_in      (wait_in),
    .fetch_access (fetch_access),
    .fetch_packet (fetch_packet),
    .access_out   (access_out),
    .dma_state    (dma_state),
    .bus          (bus.ctrl)
  );

endmodule

`default_nettype wire

/* edma_ctrl.sv */
// edma sequencer
`default_nettype none

`include "edma_settings.svh"

module edma_ctrl
  import edma_pkg::*;
(
  input  logic                clk,
  input  logic                nreset,
  input  logic                fetch_wait,     // fetch port stall
  input  logic                access_in,      // slave beat request
  input  logic                wait_in,        // beat stall
  output logic                fetch_access,
  output logic [`EDMA_PW-1:0] fetch_packet,
  output logic                access_out,     // master beat request
  output edma_state_t         dma_state,
  edma_ctrl_if.ctrl           bus
);

  edma_state_t         state;
  edma_state_t         next_state;
  logic                inner_zero;
  logic                outer_zero;
  logic                update;
  logic                enter_fetch;
  logic                sel0;            // one-hot fetch selects
  logic                sel1;
  logic                sel2;
  logic [15:0]         descr_base;
  logic [15:0]         fetch_addr;
  logic [4:0]          fetch_idx;
  logic [`EDMA_AW-1:0] fetch_src;

  // ####################
  // beat pacing
  // ####################
  assign inner_zero = ~|bus.count.half[`EDMA_CNT_INNER];
  assign outer_zero = ~|bus.count.half[`EDMA_CNT_OUTER];

  assign access_out = bus.mastermode & ((state == INNER) | (state == OUTER));
  assign update     = ~wait_in & (access_out | access_in);

  assign bus.update   = update;
  assign bus.in_outer = (state == OUTER);
  assign bus.state    = state;
  assign dma_state    = state;

  // ####################
  // state machine
  // ####################
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (bus.dma_en) begin
          next_state = bus.manualmode ? INNER : FETCH0;
        end
      end
      FETCH0:     next_state = fetch_wait ? FETCH0 : FETCH1;
      FETCH1:     next_state = fetch_wait ? FETCH1 : FETCH2;
      FETCH2:     next_state = fetch_wait ? FETCH2 : FETCH_WAIT;
      FETCH_WAIT: next_state = bus.descr_loaded ? INNER : FETCH_WAIT;
      INNER: begin
        if (update && inner_zero) begin
          next_state = outer_zero ? DONE : OUTER;   // last beat of row
        end
      end
      OUTER:      next_state = update ? INNER : OUTER;
      DONE: begin
        if (bus.chainmode) begin
          next_state = bus.manualmode ? IDLE : FETCH0;
        end else if (!bus.dma_en) begin
          next_state = IDLE;
        end
      end
      default:    next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // ####################
  // descriptor fetch
  // ####################
  assign enter_fetch = (next_state == FETCH0) & (state != FETCH0);

  // base captured once per descriptor
  always_ff @(posedge clk) begin
    if (enter_fetch) begin
      descr_base <= bus.next_descr;
    end
  end

  assign sel0 = (state == FETCH0);
  assign sel1 = (state == FETCH1);
  assign sel2 = (state == FETCH2);

  assign fetch_access = sel0 | sel1 | sel2;

  // double word offset per fetch
  assign fetch_addr = ({16{sel0}} & descr_base) |
                      ({16{sel1}} & (descr_base + 16'd8)) |
                      ({16{sel2}} & (descr_base + 16'd16));

  // first register each reply fills
  assign fetch_idx = ({5{sel0}} & `EDMA_CONFIG) |
                     ({5{sel1}} & `EDMA_COUNT) |
                     ({5{sel2}} & `EDMA_SRCADDR);

  // return address in our own register space
  assign fetch_src = {{(`EDMA_AW-11){1'b0}}, `EDMA_ID, fetch_idx, 2'b00};

  always_comb begin
    fetch_packet                              = '0;
    fetch_packet[`EDMA_P_WRITE]               = 1'b0;    // read
    fetch_packet[`EDMA_P_DMODE +: 2]          = 2'b11;   // double word
    fetch_packet[`EDMA_P_CMODE +: 5]          = 5'b0;
    fetch_packet[`EDMA_P_DST +: `EDMA_AW]     = {{(`EDMA_AW-16){1'b0}}, fetch_addr};
    fetch_packet[`EDMA_P_DATA +: `EDMA_AW]    = '0;
    fetch_packet[`EDMA_P_SRC +: `EDMA_AW]     = fetch_src;
  end

endmodule

`default_nettype wire

/* edma_regs.sv */
// edma channel registers
`default_nettype none

`include "edma_settings.svh"

module edma_regs
  import edma_pkg::*;
(
  input  logic                clk,
  input  logic                nreset,
  input  logic                reg_access,   // packet valid
  input  logic [`EDMA_PW-1:0] reg_packet,
  output logic [`EDMA_AW-1:0] srcaddr,      // current source beat address
  output logic [`EDMA_AW-1:0] dstaddr,      // current destination beat address
  edma_ctrl_if.regs           bus
);

  // packet decode
  logic                  wr_en;
  logic [4:0]            wr_idx;
  logic [`EDMA_AW-1:0]   wr_data;
  logic                  wr_cfg;
  logic                  wr_stride;
  logic                  wr_cnt;
  logic                  wr_src;
  logic                  wr_dst;

  // register state
  logic [3:0]            cfg_q;          // en master chain manual
  logic [15:0]           next_q;         // next descriptor pointer
  logic [`EDMA_AW-1:0]   stride_q;
  edma_count_u           count_q;
  logic [`EDMA_AW/2-1:0] reload_q;       // inner count as written
  logic                  descr_loaded_q;

  // stepping
  logic                  step_inner;
  logic                  step_outer;
  logic [`EDMA_AW-1:0]   stride_in;
  logic [`EDMA_AW-1:0]   stride_out;
  logic [`EDMA_AW-1:0]   step;

  // ####################
  // write decode
  // ####################
  assign wr_en   = reg_access & reg_packet[`EDMA_P_WRITE] &
                   (reg_packet[`EDMA_P_DST+7 +: 4] == `EDMA_ID);   // only our group
  assign wr_idx  = reg_packet[`EDMA_P_DST+2 +: 5];                 // word index
  assign wr_data = reg_packet[`EDMA_P_DATA +: `EDMA_AW];

  always_comb begin
    wr_cfg    = 1'b0;
    wr_stride = 1'b0;
    wr_cnt    = 1'b0;
    wr_src    = 1'b0;
    wr_dst    = 1'b0;
    if (wr_en) begin
      case (wr_idx)
        `EDMA_CONFIG:  wr_cfg    = 1'b1;
        `EDMA_STRIDE:  wr_stride = 1'b1;
        `EDMA_COUNT:   wr_cnt    = 1'b1;
        `EDMA_SPARE:   wr_cnt    = 1'b0;   // second word of fetch1 is dropped
        `EDMA_SRCADDR: wr_src    = 1'b1;
        `EDMA_DSTADDR: wr_dst    = 1'b1;
        default:       wr_cfg    = 1'b0;   // unmapped index
      endcase
    end
  end

  // ####################
  // stepping
  // ####################
  // inner beat only while rows have beats left
  assign step_inner = bus.update & (bus.state == INNER) &
                      (|count_q.half[`EDMA_CNT_INNER]);
  assign step_outer = bus.update & bus.in_outer;

  // strides are signed 16 bit
  assign stride_in  = {{(`EDMA_AW/2){stride_q[`EDMA_AW/2-1]}}, stride_q[`EDMA_AW/2-1:0]};
  assign stride_out = {{(`EDMA_AW/2){stride_q[`EDMA_AW-1]}}, stride_q[`EDMA_AW-1 -: 16]};
  assign step       = step_outer ? stride_out : stride_in;

  // control registers
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      cfg_q          <= '0;
      next_q         <= '0;
      descr_loaded_q <= 1'b0;
    end else begin
      descr_loaded_q <= wr_dst;                   // single cycle pulse
      if (wr_cfg) begin
        cfg_q  <= wr_data[3:0];
        next_q <= wr_data[`EDMA_AW-1 -: 16];
      end
    end
  end

  // loop counts where a host write wins over a step
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      count_q <= '0;
    end else if (wr_cnt) begin
      count_q.word <= wr_data;
    end else if (step_outer) begin
      count_q.half[`EDMA_CNT_OUTER] <= count_q.half[`EDMA_CNT_OUTER] - 1'b1;
      count_q.half[`EDMA_CNT_INNER] <= reload_q;  // new row
    end else if (step_inner) begin
      count_q.half[`EDMA_CNT_INNER] <= count_q.half[`EDMA_CNT_INNER] - 1'b1;
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (wr_cnt) begin
      reload_q <= wr_data[`EDMA_AW/2-1:0];
    end
    if (wr_stride) begin
      stride_q <= wr_data;
    end
    if (wr_src) begin
      srcaddr <= wr_data;
    end else if (step_inner | step_outer) begin
      srcaddr <= srcaddr + step;
    end
    if (wr_dst) begin
      dstaddr <= wr_data;
    end else if (step_inner | step_outer) begin
      dstaddr <= dstaddr + step;
    end
  end

  // to the sequencer
  assign bus.dma_en       = cfg_q[`EDMA_CFG_EN];
  assign bus.mastermode   = cfg_q[`EDMA_CFG_MASTER];
  assign bus.chainmode    = cfg_q[`EDMA_CFG_CHAIN];
  assign bus.manualmode   = cfg_q[`EDMA_CFG_MANUAL];
  assign bus.count        = count_q;
  assign bus.next_descr   = next_q;
  assign bus.descr_loaded = descr_loaded_q;

endmodule

`default_nettype wire

/* edma_ctrl_if.sv */
// edma sequencer to register link
`default_nettype none

interface edma_ctrl_if
  import edma_pkg::*;
();

  // from the register block
  logic        dma_en;         // channel enable
  logic        chainmode;      // follow next pointer
  logic        manualmode;     // no descriptor fetch
  logic        mastermode;     // self paced beats
  edma_count_u count;          // live loop counts
  logic [15:0] next_descr;     // next descriptor pointer
  logic        descr_loaded;   // last descriptor word written

  // from the sequencer
  logic        update;         // beat this cycle
  logic        in_outer;       // row jump pending
  edma_state_t state;

  modport regs (
    output dma_en, chainmode, manualmode, mastermode, count, next_descr, descr_loaded,
    input  update, in_outer, state
  );

  modport ctrl (
    input  dma_en, chainmode, manualmode, mastermode, count, next_descr, descr_loaded,
    output update, in_outer, state
  );

endinterface

`default_nettype wire

/* edma_pkg.sv */
// edma shared types
`default_nettype none

`include "edma_settings.svh"

package edma_pkg;

  // sequencer states
  typedef enum logic [3:0] {
    IDLE       = 4'd0,   // waiting for enable
    FETCH0     = 4'd1,   // config and stride
    FETCH1     = 4'd2,   // count and spare
    FETCH2     = 4'd3,   // source and destination
    FETCH_WAIT = 4'd4,   // until dstaddr lands
    INNER      = 4'd5,   // row beats
    OUTER      = 4'd6,   // row jump
    DONE       = 4'd7
  } edma_state_t;

  // count register
  // host writes the whole word
  // loops look at the two halves
  typedef union packed {
    logic [`EDMA_AW-1:0]          word;
    logic [1:0][`EDMA_AW/2-1:0]   half;   // [1] outer, [0] inner
  } edma_count_u;

endpackage

`default_nettype wire

/* edma_settings.svh */
// edma channel settings
`ifndef EDMA_SETTINGS_SVH
`define EDMA_SETTINGS_SVH

// ####################
// widths
// ####################
`define EDMA_AW 32                          // address and data width
`define EDMA_PW (2*`EDMA_AW+40)             // emesh packet width

// group id matched against register address bits 10 to 7
`define EDMA_ID 4'h5

// ####################
// emesh packet layout
// ####################
`define EDMA_P_WRITE 0                      // write flag
`define EDMA_P_DMODE 1                      // 2 bit datamode
`define EDMA_P_CMODE 3                      // 5 bit ctrlmode
`define EDMA_P_DST   8                      // destination address
`define EDMA_P_DATA  (`EDMA_P_DST+`EDMA_AW)  // write data
`define EDMA_P_SRC   (`EDMA_P_DATA+`EDMA_AW) // return address on reads

// register indices in address bits 6 to 2
`define EDMA_CONFIG  5'd0
`define EDMA_STRIDE  5'd1
`define EDMA_COUNT   5'd2
`define EDMA_SPARE   5'd3
`define EDMA_SRCADDR 5'd4
`define EDMA_DSTADDR 5'd5

// config bits (next descriptor lives in the upper half)
`define EDMA_CFG_EN     0
`define EDMA_CFG_MASTER 1
`define EDMA_CFG_CHAIN  2
`define EDMA_CFG_MANUAL 3

// count word halves
`define EDMA_CNT_INNER 0
`define EDMA_CNT_OUTER 1

`endif
